/* verilog/sbaskt_pkg.sv */
// Super Basketball board glue
// Shared address map, ROM region bounds, raster timing constants
// and the bus types passed between the CPU decoder and the RAMs

package sbaskt_pkg;

    // Scroll graphics ROM region in byte addresses
    localparam logic [21:0] scr_start = 22'h00_8000;
    localparam logic [21:0] pcm_start = 22'h01_0000;

    // Main CPU memory map
    localparam logic [15:0] vram_base  = 16'h2000;
    localparam logic [15:0] vram_words = 16'd2048;
    localparam logic [15:0] obj_base   = 16'h2800;
    localparam logic [15:0] obj_words  = 16'd256;
    localparam logic [15:0] vscr_base  = 16'h2C00;
    localparam logic [15:0] vscr_words = 16'd32;
    localparam logic [15:0] reg_base   = 16'h3000;

    // RAM select codes carried in vram_req_t
    localparam logic [1:0] sel_vram = 2'd0;
    localparam logic [1:0] sel_obj  = 2'd1;
    localparam logic [1:0] sel_vscr = 2'd2;

    // Raster size and edges in pixels and lines
    localparam logic [8:0] h_total       = 9'd384;
    localparam logic [8:0] h_blank_start = 9'd256;
    localparam logic [8:0] h_sync_start  = 9'd288;
    localparam logic [8:0] h_sync_end    = 9'd320;
    localparam logic [8:0] v_total       = 9'd264;
    localparam logic [8:0] v_blank_start = 9'd240;
    localparam logic [8:0] v_sync_start  = 9'd248;
    localparam logic [8:0] v_sync_end    = 9'd251;

    // Register block selected by the two low address bits
    typedef enum logic [1:0] {
        reg_pal     = 2'd0,
        reg_flip    = 2'd1,
        reg_irq_ack = 2'd2,
        reg_snd     = 2'd3
    } reg_op_e;

    // One main CPU bus cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        rnw;
    } cpu_bus_t;

    // Request from the decoder to the video RAMs
    typedef struct packed {
        logic [10:0] addr;
        logic [7:0]  dout;
        logic        we;
        logic [1:0]  sel;
    } vram_req_t;

endpackage

/* verilog/sbaskt_timing.sv */
// Video timing generator
// Pixel enable at half the clock rate, 384 x 264 raster,
// registered sync and blanking outputs plus V16 for the CPU

module sbaskt_timing (
    input  logic clk,
    input  logic rst_n,
    output logic HS,
    output logic VS,
    output logic LHBL,
    output logic LVBL,
    output logic V16
);
    import sbaskt_pkg::*;

    logic       pxl_cen;
    logic [8:0] h_count;
    logic [8:0] v_count;
    logic [8:0] h_next;
    logic [8:0] v_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    // Next raster position
    always_comb begin
        h_next = h_count + 9'd1;
        v_next = v_count;
        if (h_count == h_total - 9'd1) begin
            h_next = 9'd0;
            v_next = v_count + 9'd1;
            if (v_count == v_total - 9'd1) begin
                v_next = 9'd0;
            end
        end
    end

    // Outputs are decoded from the next position so they
    // change on the same edge as the counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_count <= 9'd0;
            v_count <= 9'd0;
            HS      <= 1'b0;
            VS      <= 1'b0;
            LHBL    <= 1'b1;
            LVBL    <= 1'b1;
            V16     <= 1'b0;
        end else if (pxl_cen) begin
            h_count <= h_next;
            v_count <= v_next;
            LHBL    <= h_next < h_blank_start;
            HS      <= h_next >= h_sync_start && h_next < h_sync_end;
            LVBL    <= v_next < v_blank_start;
            VS      <= v_next >= v_sync_start && v_next < v_sync_end;
            V16     <= v_next[4];
        end
    end

endmodule

/* verilog/sbaskt_sndlatch.sv */
// Main to sound CPU command latch
// The pending flag interrupts the sound CPU until it acknowledges

module sbaskt_sndlatch (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       snd_wr,
    input  logic [7:0] snd_din,
    input  logic       snd_ack,
    output logic [7:0] snd_cmd,
    output logic       snd_pending
);

    // A new write simply replaces the command byte
    always_ff @(posedge clk) begin
        if (snd_wr) begin
            snd_cmd <= snd_din;
        end
    end

    // Write has priority over ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_pending <= 1'b0;
        end else if (snd_wr) begin
            snd_pending <= 1'b1;
        end else if (snd_ack) begin
            snd_pending <= 1'b0;
        end
    end

endmodule

/* verilog/sbaskt_vram.sv */
// Video RAMs seen from the main CPU
// Tile RAM, object RAM and column scroll RAM, single port,
// with one clock of read latency

module sbaskt_vram (
    input  logic                  clk,
    input  sbaskt_pkg::vram_req_t vram_req,
    input  logic                  vram_cs,
    output logic [7:0]            vram_rdata
);
    import sbaskt_pkg::*;

    logic [7:0]  vram_mem [0:vram_words-1];
    logic [7:0]  obj_mem  [0:obj_words-1];
    logic [7:0]  vscr_mem [0:vscr_words-1];

    logic [10:0] vram_a;
    logic [7:0]  obj_a;
    logic [4:0]  vscr_a;

    assign vram_a = vram_req.addr;
    assign obj_a  = vram_req.addr[7:0];
    assign vscr_a = vram_req.addr[4:0];

    // Read happens before the write on the same cycle
    always_ff @(posedge clk) begin
        if (vram_cs) begin
            case (vram_req.sel)
                sel_vram: begin
                    if (vram_req.we) begin
                        vram_mem[vram_a] <= vram_req.dout;
                    end
                    vram_rdata <= vram_mem[vram_a];
                end
                sel_obj: begin
                    if (vram_req.we) begin
                        obj_mem[obj_a] <= vram_req.dout;
                    end
                    vram_rdata <= obj_mem[obj_a];
                end
                sel_vscr: begin
                    if (vram_req.we) begin
                        vscr_mem[vscr_a] <= vram_req.dout;
                    end
                    vram_rdata <= vscr_mem[vscr_a];
                end
                default: vram_rdata <= 8'hFF;
            endcase
        end
    end

endmodule

/* verilog/sbaskt_bus.sv */
// Main CPU bus decoder
// Maps CPU cycles onto the video RAMs and the register block,
// holds palette and flip settings and the vertical blank interrupt

module sbaskt_bus (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sbaskt_pkg::cpu_bus_t  cpu,
    input  logic                  cpu_cs,
    input  logic                  LVBL,
    input  logic [7:0]            vram_rdata,
    output logic [7:0]            cpu_din,
    output logic                  cpu_irq,
    output logic [3:0]            pal_sel,
    output logic                  flip,
    output sbaskt_pkg::vram_req_t vram_req,
    output logic                  vram_cs,
    output logic                  snd_wr,
    output logic [7:0]            snd_din
);
    import sbaskt_pkg::*;

    logic        vram_hit;
    logic        obj_hit;
    logic        vscr_hit;
    logic        reg_hit;
    logic        ram_hit;
    logic        reg_wr;
    reg_op_e     reg_op;
    logic        rd_ram;
    logic [7:0]  dout_q;
    logic        lvbl_l;
    logic        vb_fall;

    // Address decode
    assign vram_hit = cpu.addr >= vram_base && cpu.addr < vram_base + vram_words;
    assign obj_hit  = cpu.addr >= obj_base  && cpu.addr < obj_base + obj_words;
    assign vscr_hit = cpu.addr >= vscr_base && cpu.addr < vscr_base + vscr_words;
    assign reg_hit  = cpu.addr[15:2] == reg_base[15:2];
    assign ram_hit  = vram_hit | obj_hit | vscr_hit;

    assign reg_op = reg_op_e'(cpu.addr[1:0]);
    assign reg_wr = cpu_cs && !cpu.rnw && reg_hit;

    // The memory truncates the request address to its own size
    always_comb begin
        vram_req.addr = cpu.addr[10:0];
        vram_req.dout = cpu.dout;
        vram_req.we   = ~cpu.rnw;
        vram_req.sel  = sel_vram;
        if (obj_hit) begin
            vram_req.sel = sel_obj;
        end else if (vscr_hit) begin
            vram_req.sel = sel_vscr;
        end
    end

    assign vram_cs = cpu_cs & ram_hit;

    // Sound command goes straight out with a one-cycle strobe
    assign snd_wr  = reg_wr && reg_op == reg_snd;
    assign snd_din = cpu.dout;

    // Configuration registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pal_sel <= 4'd0;
            flip    <= 1'b0;
        end else if (reg_wr) begin
            case (reg_op)
                reg_pal:  pal_sel <= cpu.dout[3:0];
                reg_flip: flip    <= cpu.dout[0];
                default: ;
            endcase
        end
    end

    // Interrupt set on the falling edge of LVBL and cleared by a register write
    assign vb_fall = lvbl_l & ~LVBL;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lvbl_l  <= 1'b1;
            cpu_irq <= 1'b0;
        end else begin
            lvbl_l <= LVBL;
            if (vb_fall) begin
                cpu_irq <= 1'b1;
            end else if (reg_wr && reg_op == reg_irq_ack) begin
                cpu_irq <= 1'b0;
            end
        end
    end

    // RAM read data arrives one clock after cs and is then kept
    // in dout_q so that later RAM writes do not disturb it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ram <= 1'b0;
            dout_q <= 8'hFF;
        end else begin
            if (rd_ram) begin
                dout_q <= vram_rdata;
            end
            rd_ram <= 1'b0;
            if (cpu_cs && cpu.rnw) begin
                rd_ram <= ram_hit;
                if (!ram_hit) begin
                    dout_q <= 8'hFF;
                end
            end
        end
    end

    assign cpu_din = rd_ram ? vram_rdata : dout_q;

endmodule

/* verilog/sbaskt_game.sv */
// Super Basketball game top level
// Handles the ROM download fix-ups (scroll nibble swap, decode flag)
// and connects the bus decoder, video RAMs, sound latch and timing

module sbaskt_game (
    input  logic                 clk,
    input  logic                 rst_n,
    // Main CPU bus
    input  sbaskt_pkg::cpu_bus_t cpu,
    input  logic                 cpu_cs,
    output logic [7:0]           cpu_din,
    output logic                 cpu_irq,
    // Video configuration
    output logic [3:0]           pal_sel,
    output logic                 flip,
    // Sound CPU side
    input  logic                 snd_ack,
    output logic [7:0]           snd_cmd,
    output logic                 snd_pending,
    // ROM download
    input  logic [21:0]          prog_addr,
    input  logic [7:0]           prog_data,
    input  logic                 prog_we,
    input  logic                 header,
    output logic [7:0]           post_data,
    output logic                 decode,
    // Video timing
    output logic                 HS,
    output logic                 VS,
    output logic                 LHBL,
    output logic                 LVBL,
    output logic                 V16
);
    import sbaskt_pkg::*;

    vram_req_t   vram_req;
    logic        vram_cs;
    logic [7:0]  vram_rdata;
    logic        snd_wr;
    logic [7:0]  snd_din;
    logic        in_scr;

    // Scroll tiles are stored with swapped nibbles in the ROM set
    // Download addresses count halfwords
    assign in_scr = (prog_addr >= (scr_start >> 1)) && (prog_addr < (pcm_start >> 1));

    always_comb begin
        post_data = prog_data;
        if (in_scr) begin
            post_data = {prog_data[3:0], prog_data[7:4]};
        end
    end

    // First header byte tells whether the main CPU code is encrypted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode <= 1'b0;
        end else if (header && prog_we && prog_addr[1:0] == 2'b00) begin
            decode <= prog_data[0];
        end
    end

    sbaskt_bus u_bus (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cpu        ( cpu        ),
        .cpu_cs     ( cpu_cs     ),
        .LVBL       ( LVBL       ),
        .vram_rdata ( vram_rdata ),
        .cpu_din    ( cpu_din    ),
        .cpu_irq    ( cpu_irq    ),
        .pal_sel    ( pal_sel    ),
        .flip       ( flip       ),
        .vram_req   ( vram_req   ),
        .vram_cs    ( vram_cs    ),
        .snd_wr     ( snd_wr     ),
        .snd_din    ( snd_din    )
    );

    sbaskt_vram u_vram (
        .clk        ( clk        ),
        .vram_req   ( vram_req   ),
        .vram_cs    ( vram_cs    ),
        .vram_rdata ( vram_rdata )
    );

    sbaskt_sndlatch u_sndlatch (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .snd_wr      ( snd_wr      ),
        .snd_din     ( snd_din     ),
        .snd_ack     ( snd_ack     ),
        .snd_cmd     ( snd_cmd     ),
        .snd_pending ( snd_pending )
    );

    sbaskt_timing u_timing (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .HS    ( HS    ),
        .VS    ( VS    ),
        .LHBL  ( LHBL  ),
        .LVBL  ( LVBL  ),
        .V16   ( V16   )
    );

endmodule

/* verification/sbaskt_tb.sv */
// Testbench for the Super Basketball board glue
// Acts as main CPU, sound CPU and ROM loader at once and compares
// every DUT output with a cycle model kept in the testbench

module sbaskt_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import sbaskt_pkg::*;

    typedef enum logic [2:0] {r_none, r_vram, r_obj, r_vscr, r_reg} region_e;
    typedef enum logic [2:0] {w_hs, w_vs, w_lhbl, w_lvbl, w_v16, w_irq} watch_e;

    logic        clk;
    logic        rst_n;
    cpu_bus_t    cpu;
    logic        cpu_cs;
    logic        snd_ack;
    logic [21:0] prog_addr;
    logic [7:0]  prog_data;
    logic        prog_we;
    logic        header;
    logic [7:0]  cpu_din;
    logic        cpu_irq;
    logic [3:0]  pal_sel;
    logic        flip;
    logic [7:0]  snd_cmd;
    logic        snd_pending;
    logic [7:0]  post_data;
    logic        decode;
    logic        HS;
    logic        VS;
    logic        LHBL;
    logic        LVBL;
    logic        V16;

    // Reference model
    logic        checking;
    logic [7:0]  vram_m [0:2047];
    logic [7:0]  obj_m  [0:255];
    logic [7:0]  vscr_m [0:31];
    logic [7:0]  m_din;
    logic [7:0]  m_cmd;
    logic [3:0]  m_pal;
    logic        m_flip;
    logic        m_irq;
    logic        m_pend;
    logic        m_decode;
    logic        cmd_known;
    logic        m_cen;
    logic        m_lvbl_d;
    logic [8:0]  m_h;
    logic [8:0]  m_v;
    logic        e_hs;
    logic        e_vs;
    logic        e_lhbl;
    logic        e_lvbl;
    logic        irq_ack_wr;
    logic [15:0] addr_q [$];
    logic [15:0] a;
    logic [7:0]  cmd_byte;
    int          n;

    sbaskt_game u_sbaskt_game (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic region_e region_of(input logic [15:0] addr);
        if (addr >= vram_base && addr < vram_base + vram_words) return r_vram;
        if (addr >= obj_base && addr < obj_base + obj_words) return r_obj;
        if (addr >= vscr_base && addr < vscr_base + vscr_words) return r_vscr;
        if (addr >= reg_base && addr < reg_base + 16'd4) return r_reg;
        return r_none;
    endfunction

    // Scroll graphics bytes come out with their nibbles exchanged
    function automatic logic [7:0] swap_expect(input logic [21:0] addr, input logic [7:0] data);
        if (addr >= scr_start / 2 && addr < pcm_start / 2) return {data[3:0], data[7:4]};
        return data;
    endfunction

    function automatic logic probe(input watch_e sel);
        case (sel)
            w_hs:    return HS;
            w_vs:    return VS;
            w_lhbl:  return LHBL;
            w_lvbl:  return LVBL;
            w_v16:   return V16;
            default: return cpu_irq;
        endcase
    endfunction

    // Two frames worth of clocks
    function automatic int frame_clocks();
        return 4 * int'(h_total) * int'(v_total);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
        else report_failure($sformatf("Fail %s expected %0h got %0h", name, exp, got));
    endtask

    task automatic wait_for(input watch_e sel, input logic level, input int limit);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (probe(sel) !== level && cnt < limit) begin
            @(negedge clk);
            cnt++;
        end
        if (probe(sel) !== level) begin
            report_failure($sformatf("Timeout waiting for %s to become %0d", sel.name(), level));
        end
    endtask

    // Clocks spent at the given level from its next start
    task automatic run_length(input watch_e sel, input logic level, output int clocks);
        int cnt;
        wait_for(sel, ~level, frame_clocks());
        wait_for(sel, level, frame_clocks());
        cnt = 0;
        while (probe(sel) === level && cnt < frame_clocks()) begin
            @(negedge clk);
            cnt++;
        end
        if (probe(sel) === level) begin
            report_failure($sformatf("%s never left its level", sel.name()));
        end
        clocks = cnt;
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data,
                             input logic with_ack = 1'b0);
        @(posedge clk);
        cpu     <= {addr, data, 1'b0};
        cpu_cs  <= 1'b1;
        snd_ack <= with_ack;
        @(posedge clk);
        cpu_cs  <= 1'b0;
        snd_ack <= 1'b0;
    endtask

    task automatic cpu_read(input logic [15:0] addr);
        @(posedge clk);
        cpu    <= {addr, 8'h00, 1'b1};
        cpu_cs <= 1'b1;
        @(posedge clk);
        cpu_cs <= 1'b0;
    endtask

    task automatic download(input logic [21:0] addr, input logic [7:0] data, input logic hdr);
        @(posedge clk);
        prog_addr <= addr;
        prog_data <= data;
        prog_we   <= 1'b1;
        header    <= hdr;
        @(posedge clk);
        prog_we   <= 1'b0;
        header    <= 1'b0;
    endtask

    task automatic sound_ack();
        @(posedge clk);
        snd_ack <= 1'b1;
        @(posedge clk);
        snd_ack <= 1'b0;
    endtask

    assign e_lhbl = m_h < h_blank_start;
    assign e_hs   = m_h >= h_sync_start && m_h < h_sync_end;
    assign e_lvbl = m_v < v_blank_start;
    assign e_vs   = m_v >= v_sync_start && m_v < v_sync_end;
    assign irq_ack_wr = cpu_cs && !cpu.rnw && region_of(cpu.addr) == r_reg
                        && reg_op_e'(cpu.addr[1:0]) == reg_irq_ack;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {m_pal, m_flip, m_irq, m_pend, m_decode, cmd_known, m_cen} <= '0;
            m_din    <= 8'hFF;
            m_lvbl_d <= 1'b1;
            m_h      <= 9'd0;
            m_v      <= 9'd0;
        end else begin
            m_cen <= ~m_cen;
            if (m_cen) begin
                m_h <= (m_h == h_total - 9'd1) ? 9'd0 : m_h + 9'd1;
                if (m_h == h_total - 9'd1) m_v <= (m_v == v_total - 9'd1) ? 9'd0 : m_v + 9'd1;
            end
            m_lvbl_d <= e_lvbl;
            if (m_lvbl_d && !e_lvbl) m_irq <= 1'b1;
            else if (irq_ack_wr) m_irq <= 1'b0;
            if (header && prog_we && prog_addr[1:0] == 2'b00) m_decode <= prog_data[0];
            if (snd_ack) m_pend <= 1'b0;
            if (cpu_cs) begin
                case (region_of(cpu.addr))
                    r_vram: begin
                        if (cpu.rnw) m_din <= vram_m[11'(cpu.addr - vram_base)];
                        else vram_m[11'(cpu.addr - vram_base)] <= cpu.dout;
                    end
                    r_obj: begin
                        if (cpu.rnw) m_din <= obj_m[8'(cpu.addr - obj_base)];
                        else obj_m[8'(cpu.addr - obj_base)] <= cpu.dout;
                    end
                    r_vscr: begin
                        if (cpu.rnw) m_din <= vscr_m[5'(cpu.addr - vscr_base)];
                        else vscr_m[5'(cpu.addr - vscr_base)] <= cpu.dout;
                    end
                    r_reg: begin
                        if (cpu.rnw) m_din <= 8'hFF;
                        else if (reg_op_e'(cpu.addr[1:0]) == reg_pal) m_pal <= cpu.dout[3:0];
                        else if (reg_op_e'(cpu.addr[1:0]) == reg_flip) m_flip <= cpu.dout[0];
                        else if (reg_op_e'(cpu.addr[1:0]) == reg_snd) begin
                            m_cmd     <= cpu.dout;
                            m_pend    <= 1'b1;
                            cmd_known <= 1'b1;
                        end
                    end
                    default: if (cpu.rnw) m_din <= 8'hFF;
                endcase
            end
        end
    end

    // Every output against the model once per cycle
    always @(negedge clk) begin
        if (checking) begin
            check_eq("post_data", 32'(swap_expect(prog_addr, prog_data)), 32'(post_data));
            check_eq("decode", 32'(m_decode), 32'(decode));
            check_eq("cpu_din", 32'(m_din), 32'(cpu_din));
            check_eq("cpu_irq", 32'(m_irq), 32'(cpu_irq));
            check_eq("pal_sel", 32'(m_pal), 32'(pal_sel));
            check_eq("flip", 32'(m_flip), 32'(flip));
            check_eq("snd_pending", 32'(m_pend), 32'(snd_pending));
            if (cmd_known) check_eq("snd_cmd", 32'(m_cmd), 32'(snd_cmd));
            check_eq("HS", 32'(e_hs), 32'(HS));
            check_eq("VS", 32'(e_vs), 32'(VS));
            check_eq("LHBL", 32'(e_lhbl), 32'(LHBL));
            check_eq("LVBL", 32'(e_lvbl), 32'(LVBL));
            check_eq("V16", 32'(m_v[4]), 32'(V16));
        end
    end

    // Sync pulses sit inside their blanking intervals
    assert property (@(posedge clk) disable iff (!rst_n) HS |-> !LHBL)
    else report_failure("HS active outside horizontal blanking");
    assert property (@(posedge clk) disable iff (!rst_n) VS |-> !LVBL)
    else report_failure("VS active outside vertical blanking");

    initial begin
        void'($urandom(32'h8ae0_9484));
        checking  = 1'b0;
        rst_n     = 1'b0;
        cpu       = {16'h0000, 8'h00, 1'b1};
        cpu_cs    = 1'b0;
        snd_ack   = 1'b0;
        prog_addr = 22'd0;
        prog_data = 8'h00;
        prog_we   = 1'b0;
        header    = 1'b0;
        @(posedge clk);
        checking = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Scroll region edges and random addresses around it
        download(22'h00_3FFF, 8'($urandom), 1'b0);
        download(22'h00_4000, 8'($urandom), 1'b0);
        download(22'h00_7FFF, 8'($urandom), 1'b0);
        download(22'h00_8000, 8'($urandom), 1'b0);
        repeat (8) download(22'h00_4000 + 22'($urandom_range(0, 16383)), 8'($urandom), 1'b0);
        repeat (8) download(22'($urandom), 8'($urandom), 1'b0);

        // Decode flag only from header bytes at offset 0
        download(22'h00_0000, 8'h01, 1'b1);
        download(22'h00_0001, 8'h00, 1'b1);
        download(22'h00_0004, 8'h00, 1'b0);
        download(22'h00_0004, 8'h00, 1'b1);
        download(22'h00_0005, 8'h01, 1'b1);
        download(22'h00_0008, 8'h01, 1'b1);

        // Region edges first, then random locations
        addr_q = '{16'h2000, 16'h27FF, 16'h2800, 16'h28FF, 16'h2C00, 16'h2C1F};
        repeat (24) begin
            case ($urandom_range(0, 2))
                0: a = vram_base + 16'($urandom_range(0, 2047));
                1: a = obj_base + 16'($urandom_range(0, 255));
                default: a = vscr_base + 16'($urandom_range(0, 31));
            endcase
            addr_q.push_back(a);
        end
        foreach (addr_q[i]) cpu_write(addr_q[i], 8'($urandom));
        foreach (addr_q[i]) cpu_read(addr_q[i]);
        cpu_read(16'h1FFF);
        cpu_read(addr_q[0]);
        cpu_read(16'h2900);
        cpu_read(16'h2C20);
        cpu_read(16'h3001);

        // Palette and flip
        cpu_write(reg_base, 8'($urandom));
        cpu_write(reg_base + 16'd1, 8'h01);
        cpu_write(reg_base, 8'hA5);
        cpu_write(reg_base + 16'd1, 8'hFE);

        // Sound latch, overwrite, ack and write against ack
        cmd_byte = 8'($urandom);
        cpu_write(reg_base + 16'd3, cmd_byte);
        cpu_write(reg_base + 16'd3, ~cmd_byte);
        sound_ack();
        cpu_write(reg_base + 16'd3, 8'($urandom), 1'b1);
        sound_ack();

        // Raster widths measured in clocks at two per pixel
        run_length(w_lhbl, 1'b0, n);
        check_eq("LHBL low pixels", 32'd128, 32'(n / 2));
        run_length(w_lhbl, 1'b1, n);
        check_eq("LHBL high pixels", 32'd256, 32'(n / 2));
        run_length(w_hs, 1'b1, n);
        check_eq("HS pixels", 32'd32, 32'(n / 2));
        run_length(w_v16, 1'b1, n);
        check_eq("V16 high lines", 32'd16, 32'(n / 2 / int'(h_total)));
        run_length(w_v16, 1'b0, n);
        check_eq("V16 low lines", 32'd16, 32'(n / 2 / int'(h_total)));
        run_length(w_lvbl, 1'b0, n);
        check_eq("LVBL low lines", 32'd24, 32'(n / 2 / int'(h_total)));
        run_length(w_vs, 1'b1, n);
        check_eq("VS lines", 32'd3, 32'(n / 2 / int'(h_total)));

        // Vertical blank interrupt and its acknowledge
        wait_for(w_irq, 1'b1, frame_clocks());
        cpu_write(reg_base + 16'd2, 8'h00);
        wait_for(w_irq, 1'b0, 4);
        wait_for(w_lvbl, 1'b1, frame_clocks());
        wait_for(w_lvbl, 1'b0, frame_clocks());
        wait_for(w_irq, 1'b1, 2);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* build.f */
verilog/sbaskt_pkg.sv
verilog/sbaskt_timing.sv
verilog/sbaskt_sndlatch.sv
verilog/sbaskt_vram.sv
verilog/sbaskt_bus.sv
verilog/sbaskt_game.sv
verification/sbaskt_tb.sv

/* run.sh */
#!/bin/sh
# Compile the testbench and RTL with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sbaskt_tb -f build.f -o sbaskt_sim

./obj_dir/sbaskt_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
